// File: design/analog_pkg.sv
// Shared widths, sample types and generator opcodes of the analog datapath
// Every RTL module refers to these by scoped name

package analog_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int ADC_RAW_W = 16;  // Raw ADC word, two LSBs unused
  localparam int SAMPLE_W  = 14;  // Signed sample width

  ////////////////////////////////////////////////////////////////////////////
  // Sample types
  ////////////////////////////////////////////////////////////////////////////

  // One 14-bit two's complement sample
  typedef logic signed [SAMPLE_W-1:0] sample_t;

  // Sum of two samples, one guard bit
  typedef logic signed [SAMPLE_W:0] sum_t;

  // One sample per channel, a in the upper half
  typedef struct packed {
    sample_t a;  // Channel 1
    sample_t b;  // Channel 2
  } ch_pair_t;

  // Generator opcode
  typedef enum logic [1:0] {
    GEN_OFF   = 2'd0,  // Output zero
    GEN_CONST = 2'd1,  // DC level on both channels
    GEN_RAMP  = 2'd2   // Sawtooth from phase accumulator
  } gen_mode_e;

  ////////////////////////////////////////////////////////////////////////////
  // Saturation limits
  ////////////////////////////////////////////////////////////////////////////

  localparam sample_t SAMPLE_MAX = sample_t'(8191);   // Full scale positive
  localparam sample_t SAMPLE_MIN = sample_t'(-8192);  // Full scale negative

endpackage

// File: design/adc_frontend.sv
// ADC capture stage, drops the ADC LSBs and converts offset code to signed
// Loopback mode feeds the last mixer sample back in place of the ADC words

`timescale 1ns/100ps

module adc_frontend (
  input  logic                                 adc_clk,
  input  logic                                 rst_n_i,      // Sync, active low
  input  logic                                 adc_valid_i,  // Sample strobe
  input  logic [analog_pkg::ADC_RAW_W-1:0]     adc_dat_a_i,  // Raw word ch a
  input  logic [analog_pkg::ADC_RAW_W-1:0]     adc_dat_b_i,  // Raw word ch b
  input  logic                                 loop_en_i,    // Digital loopback
  input  analog_pkg::ch_pair_t                 dac_pair_i,   // Last mixer output
  output analog_pkg::ch_pair_t                 in_pair_o,
  output logic                                 in_vld_o
);

//////////////////////////////////////////////////////////////////////////////
// Code conversion
//////////////////////////////////////////////////////////////////////////////

  // Negative slope offset code to two's complement
  function automatic analog_pkg::sample_t adc_to_signed(
    input logic [analog_pkg::ADC_RAW_W-1:0] raw
  );
    logic [analog_pkg::SAMPLE_W-1:0] top;
    top = raw[analog_pkg::ADC_RAW_W-1 -: analog_pkg::SAMPLE_W];  // Keep 15..2
    // Sign stays, magnitude bits flip
    return {top[analog_pkg::SAMPLE_W-1], ~top[analog_pkg::SAMPLE_W-2:0]};
  endfunction

  analog_pkg::ch_pair_t adc_pair;  // Converted ADC words
  analog_pkg::ch_pair_t sel_pair;  // After loopback mux

  assign adc_pair.a = adc_to_signed(adc_dat_a_i);
  assign adc_pair.b = adc_to_signed(adc_dat_b_i);
  assign sel_pair   = loop_en_i ? dac_pair_i : adc_pair;  // Loopback wins

//////////////////////////////////////////////////////////////////////////////
// Input register
//////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      in_pair_o <= '0;    // Zero pair out of reset
      in_vld_o  <= 1'b0;
    end
    else
    begin
      in_vld_o <= adc_valid_i;  // One cycle latency
      if (adc_valid_i)
      begin
        in_pair_o <= sel_pair;  // Hold between strobes
      end
    end
  end

//////////////////////////////////////////////////////////////////////////////
// Checks
//////////////////////////////////////////////////////////////////////////////

  // Strobe leaves exactly one cycle after it arrives
  a_vld_delay : assert property (
    @(posedge adc_clk) disable iff (!rst_n_i)
    $past(rst_n_i) |-> (in_vld_o == $past(adc_valid_i))
  );

endmodule

// File: design/waveform_generator.sv
// Stand-in for the arbitrary signal generator, one sample per input strobe
// Off, constant level or a ramp from a wrapping phase accumulator

`timescale 1ns/100ps

module waveform_generator #(
  parameter int ACC_W = 24  // Phase accumulator width
)(
  input  logic                   adc_clk,
  input  logic                   rst_n_i,      // Sync, active low
  input  logic                   in_vld_i,     // Sample strobe from frontend
  input  analog_pkg::gen_mode_e  gen_mode_i,   // Opcode
  input  analog_pkg::sample_t    gen_level_i,  // Constant mode level
  input  logic [ACC_W-1:0]       gen_step_i,   // Ramp increment per sample
  output analog_pkg::ch_pair_t   gen_pair_o,
  output logic                   gen_vld_o
);

  logic [ACC_W-1:0]      acc;       // Ramp phase
  logic [ACC_W-1:0]      acc_nxt;   // Phase after this sample
  analog_pkg::sample_t   ramp_a;    // Ramp sample, channel a
  analog_pkg::ch_pair_t  pair_nxt;  // Sample to register

//////////////////////////////////////////////////////////////////////////////
// Next sample
//////////////////////////////////////////////////////////////////////////////

  assign acc_nxt = acc + gen_step_i;  // Wraps at 2**ACC_W
  assign ramp_a  = acc_nxt[ACC_W-1 -: analog_pkg::SAMPLE_W];  // Top bits

  always_comb
  begin
    case (gen_mode_i)
      analog_pkg::GEN_CONST:
      begin
        pair_nxt.a = gen_level_i;
        pair_nxt.b = gen_level_i;
      end
      analog_pkg::GEN_RAMP:
      begin
        pair_nxt.a = ramp_a;
        // Same ramp shifted by half a period
        pair_nxt.b = {~ramp_a[analog_pkg::SAMPLE_W-1],
                      ramp_a[analog_pkg::SAMPLE_W-2:0]};
      end
      default:
        pair_nxt = '0;  // GEN_OFF
    endcase
  end

//////////////////////////////////////////////////////////////////////////////
// Registers
//////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      acc        <= '0;
      gen_pair_o <= '0;
      gen_vld_o  <= 1'b0;
    end
    else
    begin
      gen_vld_o <= in_vld_i;
      if (gen_mode_i != analog_pkg::GEN_RAMP)
        acc <= '0;               // Ramp restarts from zero phase
      else if (in_vld_i)
        acc <= acc_nxt;          // One step per sample
      if (in_vld_i)
        gen_pair_o <= pair_nxt;
    end
  end

  // Opcode must be a defined mode whenever a sample is taken
  a_mode_legal : assert property (
    @(posedge adc_clk) disable iff (!rst_n_i)
    in_vld_i |-> gen_mode_i inside {analog_pkg::GEN_OFF, analog_pkg::GEN_CONST,
                                    analog_pkg::GEN_RAMP}
  );

endmodule

// File: design/p_controller.sv
// Stand-in for the PID, proportional term only on each channel
// Output = clamp(((setpoint - input) * kp) >>> KP_SHIFT)

`timescale 1ns/100ps

module p_controller #(
  parameter int KP_SHIFT = 6  // Gain fraction bits
)(
  input  logic                  adc_clk,
  input  logic                  rst_n_i,     // Sync, active low
  input  analog_pkg::ch_pair_t  in_pair_i,   // Measured samples
  input  logic                  in_vld_i,
  input  analog_pkg::sample_t   setpoint_i,  // Shared by both channels
  input  logic signed [7:0]     kp_i,        // Signed gain
  output analog_pkg::ch_pair_t  ctl_pair_o,
  output logic                  ctl_vld_o
);

  // Error is one bit wider than a sample, gain adds eight more
  localparam int PROD_W = analog_pkg::SAMPLE_W + 1 + 8;

  analog_pkg::ch_pair_t ctl_nxt;  // Clamped terms

//////////////////////////////////////////////////////////////////////////////
// Proportional term
//////////////////////////////////////////////////////////////////////////////

  function automatic analog_pkg::sample_t p_term(
    input analog_pkg::sample_t sp,
    input analog_pkg::sample_t x,
    input logic signed [7:0]   kp
  );
    analog_pkg::sum_t          err;     // Setpoint minus input
    logic signed [PROD_W-1:0]  prod;    // Full precision product
    logic signed [PROD_W-1:0]  scaled;  // After gain shift
    err    = analog_pkg::sum_t'(sp) - analog_pkg::sum_t'(x);  // Cannot overflow
    prod   = err * kp;
    scaled = prod >>> KP_SHIFT;  // Arithmetic, rounds toward minus infinity
    if (scaled > analog_pkg::SAMPLE_MAX)
      return analog_pkg::SAMPLE_MAX;
    else if (scaled < analog_pkg::SAMPLE_MIN)
      return analog_pkg::SAMPLE_MIN;
    else
      return analog_pkg::sample_t'(scaled);
  endfunction

  assign ctl_nxt.a = p_term(setpoint_i, in_pair_i.a, kp_i);
  assign ctl_nxt.b = p_term(setpoint_i, in_pair_i.b, kp_i);

//////////////////////////////////////////////////////////////////////////////
// Output register
//////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      ctl_pair_o <= '0;
      ctl_vld_o  <= 1'b0;
    end
    else
    begin
      ctl_vld_o <= in_vld_i;  // Lines up with generator strobe
      if (in_vld_i)
      begin
        ctl_pair_o <= ctl_nxt;
      end
    end
  end

endmodule

// File: design/dac_mixer.sv
// Adds generator and controller outputs, saturates and forms DAC codes
// The signed result also goes back to the frontend for loopback

`timescale 1ns/100ps

module dac_mixer (
  input  logic                                 adc_clk,
  input  logic                                 rst_n_i,      // Sync, active low
  input  analog_pkg::ch_pair_t                 gen_pair_i,   // Generator samples
  input  logic                                 gen_vld_i,    // Also times ctl_pair_i
  input  analog_pkg::ch_pair_t                 ctl_pair_i,   // Controller samples
  output analog_pkg::ch_pair_t                 out_pair_o,   // Saturated signed sum
  output logic [analog_pkg::SAMPLE_W-1:0]      dac_dat_a_o,  // Neg-slope DAC code
  output logic [analog_pkg::SAMPLE_W-1:0]      dac_dat_b_o,
  output logic [1:0]                           dac_sat_o,    // [0] ch a, [1] ch b
  output logic                                 dac_valid_o
);

  localparam logic [analog_pkg::SAMPLE_W-1:0] DAC_ZERO = 14'h1fff;  // Code of 0

  analog_pkg::sum_t      sum_a;     // Raw sums
  analog_pkg::sum_t      sum_b;
  analog_pkg::ch_pair_t  sat_pair;  // Clamped sums
  logic [1:0]            sat_flag;  // Clamp happened

//////////////////////////////////////////////////////////////////////////////
// Sum and saturation
//////////////////////////////////////////////////////////////////////////////

  function automatic analog_pkg::sample_t clamp(input analog_pkg::sum_t s);
    if (s > analog_pkg::SAMPLE_MAX)
      return analog_pkg::SAMPLE_MAX;
    else if (s < analog_pkg::SAMPLE_MIN)
      return analog_pkg::SAMPLE_MIN;
    else
      return analog_pkg::sample_t'(s);
  endfunction

  // Signed to negative slope offset code
  function automatic logic [analog_pkg::SAMPLE_W-1:0] to_dac(
    input analog_pkg::sample_t s
  );
    return {s[analog_pkg::SAMPLE_W-1], ~s[analog_pkg::SAMPLE_W-2:0]};
  endfunction

  assign sum_a = analog_pkg::sum_t'(gen_pair_i.a) + analog_pkg::sum_t'(ctl_pair_i.a);
  assign sum_b = analog_pkg::sum_t'(gen_pair_i.b) + analog_pkg::sum_t'(ctl_pair_i.b);

  assign sat_pair.a = clamp(sum_a);
  assign sat_pair.b = clamp(sum_b);

  // Guard bit differs from sign when out of range
  assign sat_flag = {sum_b[analog_pkg::SAMPLE_W] ^ sum_b[analog_pkg::SAMPLE_W-1],
                     sum_a[analog_pkg::SAMPLE_W] ^ sum_a[analog_pkg::SAMPLE_W-1]};

//////////////////////////////////////////////////////////////////////////////
// Output registers
//////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      out_pair_o  <= '0;
      dac_dat_a_o <= DAC_ZERO;  // DAC idles at mid scale
      dac_dat_b_o <= DAC_ZERO;
      dac_sat_o   <= 2'b00;
      dac_valid_o <= 1'b0;
    end
    else
    begin
      dac_valid_o <= gen_vld_i;
      dac_sat_o   <= gen_vld_i ? sat_flag : 2'b00;  // Pulse with the sample
      if (gen_vld_i)
      begin
        out_pair_o  <= sat_pair;
        dac_dat_a_o <= to_dac(sat_pair.a);
        dac_dat_b_o <= to_dac(sat_pair.b);
      end
    end
  end

  // Saturation flags only qualify a valid sample
  a_sat_qual : assert property (
    @(posedge adc_clk) disable iff (!rst_n_i)
    !dac_valid_o |-> (dac_sat_o == 2'b00)
  );

endmodule

// File: design/analog_loop_top.sv
// Top level of the analog loop, ADC frontend into generator and P controller
// Their mixed sum drives the DAC ports three cycles after each ADC strobe

`timescale 1ns/100ps

module analog_loop_top #(
  parameter int ACC_W    = 24,  // Generator phase accumulator
  parameter int KP_SHIFT = 6    // Controller gain shift
)(
  input  logic                                 adc_clk,
  input  logic                                 rst_n_i,      // Sync, active low
  // ADC
  input  logic                                 adc_valid_i,  // Sample strobe
  input  logic [analog_pkg::ADC_RAW_W-1:0]     adc_dat_a_i,
  input  logic [analog_pkg::ADC_RAW_W-1:0]     adc_dat_b_i,
  // Configuration
  input  logic                                 loop_en_i,    // Digital loopback
  input  analog_pkg::gen_mode_e                gen_mode_i,
  input  analog_pkg::sample_t                  gen_level_i,
  input  logic [ACC_W-1:0]                     gen_step_i,
  input  analog_pkg::sample_t                  setpoint_i,
  input  logic signed [7:0]                    kp_i,
  // DAC
  output logic [analog_pkg::SAMPLE_W-1:0]      dac_dat_a_o,  // Neg-slope code
  output logic [analog_pkg::SAMPLE_W-1:0]      dac_dat_b_o,
  output analog_pkg::sample_t                  out_a_o,      // Signed sum ch a
  output analog_pkg::sample_t                  out_b_o,      // Signed sum ch b
  output logic [1:0]                           dac_sat_o,
  output logic                                 dac_valid_o
);

  analog_pkg::ch_pair_t in_pair;   // Converted input
  logic                 in_vld;
  analog_pkg::ch_pair_t gen_pair;  // Generator output
  logic                 gen_vld;   // Also marks ctl_pair
  analog_pkg::ch_pair_t ctl_pair;  // Controller output
  analog_pkg::ch_pair_t out_pair;  // Mixer result, loopback source

  adc_frontend i_frontend (
    .adc_clk     (adc_clk    ),
    .rst_n_i     (rst_n_i    ),
    .adc_valid_i (adc_valid_i),
    .adc_dat_a_i (adc_dat_a_i),
    .adc_dat_b_i (adc_dat_b_i),
    .loop_en_i   (loop_en_i  ),
    .dac_pair_i  (out_pair   ),
    .in_pair_o   (in_pair    ),
    .in_vld_o    (in_vld     )
  );

  waveform_generator #(.ACC_W (ACC_W)) i_gen (
    .adc_clk (adc_clk), .rst_n_i (rst_n_i), .in_vld_i (in_vld),
    .gen_mode_i (gen_mode_i), .gen_level_i (gen_level_i), .gen_step_i (gen_step_i),
    .gen_pair_o (gen_pair), .gen_vld_o (gen_vld)
  );

  // Strobe equals gen_vld every cycle, the mixer times both pairs on that
  p_controller #(.KP_SHIFT (KP_SHIFT)) i_ctl (
    .adc_clk (adc_clk), .rst_n_i (rst_n_i), .in_pair_i (in_pair), .in_vld_i (in_vld),
    .setpoint_i (setpoint_i), .kp_i (kp_i), .ctl_pair_o (ctl_pair), .ctl_vld_o ()
  );

  dac_mixer i_mixer (
    .adc_clk (adc_clk), .rst_n_i (rst_n_i),
    .gen_pair_i (gen_pair), .gen_vld_i (gen_vld), .ctl_pair_i (ctl_pair),
    .out_pair_o (out_pair), .dac_dat_a_o (dac_dat_a_o), .dac_dat_b_o (dac_dat_b_o),
    .dac_sat_o (dac_sat_o), .dac_valid_o (dac_valid_o)
  );

  // Flattened mixer result
  assign out_a_o = out_pair.a;
  assign out_b_o = out_pair.b;

endmodule

// File: test/tb_analog_loop.sv
// Self-checking testbench for the analog loop top level
// Drives ADC samples and configuration, predicts every DAC sample and compares

`timescale 1ns/100ps

module tb_analog_loop;

  localparam int ACC_W    = 24;
  localparam int KP_SHIFT = 6;
  localparam int N_CONST  = 16;  // 4 levels x 4 samples
  localparam int N_CTL    = 30;  // 6 gains x 5 samples
  localparam int N_RAMP   = 20;
  localparam int N_SAT    = 6;
  localparam int N_LOOP   = 40;
  localparam int N_TOTAL  = N_CONST + N_CTL + N_RAMP + N_SAT + N_LOOP;
  localparam int TIMEOUT_CYCLES = 6 * N_TOTAL + 50;

  // One predicted DAC sample
  typedef struct packed {
    logic signed [13:0] out_a;
    logic signed [13:0] out_b;
    logic [13:0]        dac_a;
    logic [13:0]        dac_b;
    logic [1:0]         sat;
    logic [31:0]        issue_cyc;  // Cycle of the ADC strobe
  } expect_t;

  logic                   adc_clk;
  logic                   rst_n_i;
  logic                   adc_valid_i;
  logic [15:0]            adc_dat_a_i;
  logic [15:0]            adc_dat_b_i;
  logic                   loop_en_i;
  analog_pkg::gen_mode_e  gen_mode_i;
  analog_pkg::sample_t    gen_level_i;
  logic [ACC_W-1:0]       gen_step_i;
  analog_pkg::sample_t    setpoint_i;
  logic signed [7:0]      kp_i;
  logic [13:0]            dac_dat_a_o;
  logic [13:0]            dac_dat_b_o;
  analog_pkg::sample_t    out_a_o;
  analog_pkg::sample_t    out_b_o;
  logic [1:0]             dac_sat_o;
  logic                   dac_valid_o;

  expect_t           expected[$];  // In-flight predictions with the oldest first
  expect_t           exp_s;
  logic [ACC_W-1:0]  model_acc;    // Model ramp phase
  int                prev_a;       // Model of the loopback pair
  int                prev_b;
  int                cycle;
  int                errors;
  int                issued;
  int                seed;

  analog_loop_top dut (
    .adc_clk     (adc_clk    ),
    .rst_n_i     (rst_n_i    ),
    .adc_valid_i (adc_valid_i),
    .adc_dat_a_i (adc_dat_a_i),
    .adc_dat_b_i (adc_dat_b_i),
    .loop_en_i   (loop_en_i  ),
    .gen_mode_i  (gen_mode_i ),
    .gen_level_i (gen_level_i),
    .gen_step_i  (gen_step_i ),
    .setpoint_i  (setpoint_i ),
    .kp_i        (kp_i       ),
    .dac_dat_a_o (dac_dat_a_o),
    .dac_dat_b_o (dac_dat_b_o),
    .out_a_o     (out_a_o    ),
    .out_b_o     (out_b_o    ),
    .dac_sat_o   (dac_sat_o  ),
    .dac_valid_o (dac_valid_o)
  );

  initial
  begin
    adc_clk = 1'b0;
    forever #50 adc_clk = ~adc_clk;  // 100 ns period
  end

//////////////////////////////////////////////////////////////////////////////
// Reference model
//////////////////////////////////////////////////////////////////////////////

  function automatic int clamp_sample(input int v);
    if (v > 8191)
      return 8191;
    else if (v < -8192)
      return -8192;
    return v;
  endfunction

  // Error times gain divided by 2**KP_SHIFT rounding down and then clamped
  function automatic int prop_term(input int sp, input int x, input int kp);
    int prod;
    int d;
    prod = (sp - x) * kp;
    d    = 1 << KP_SHIFT;
    if (prod >= 0)
      return clamp_sample(prod / d);
    return clamp_sample(-((-prod + d - 1) / d));
  endfunction

  function automatic expect_t model_sample(
    input logic [15:0]           raw_a,
    input logic [15:0]           raw_b,
    input analog_pkg::gen_mode_e mode,
    input int                    level,
    input logic [ACC_W-1:0]      acc,
    input logic [ACC_W-1:0]      step,
    input int                    setpoint,
    input int                    kp,
    input bit                    loop_en,
    input int                    last_a,
    input int                    last_b
  );
    expect_t          e;
    logic [ACC_W-1:0] phase;
    int               x_a;
    int               x_b;
    int               g_a;
    int               g_b;
    int               s_a;
    int               s_b;
    // Offset code gives +8191 at code zero and one LSB less per step
    x_a = loop_en ? last_a : 8191 - int'(raw_a[15:2]);
    x_b = loop_en ? last_b : 8191 - int'(raw_b[15:2]);
    g_a = 0;
    g_b = 0;
    if (mode == analog_pkg::GEN_CONST)
    begin
      g_a = level;
      g_b = level;
    end
    else if (mode == analog_pkg::GEN_RAMP)
    begin
      phase = acc + step;                   // Wraps like the hardware
      g_a   = int'(phase[ACC_W-1 -: 14]);
      if (g_a > 8191)
        g_a = g_a - 16384;                  // Top bits read as signed
      g_b = (g_a < 0) ? g_a + 8192 : g_a - 8192;  // Sign bit flipped
    end
    s_a         = g_a + prop_term(setpoint, x_a, kp);
    s_b         = g_b + prop_term(setpoint, x_b, kp);
    e.sat       = {s_b != clamp_sample(s_b), s_a != clamp_sample(s_a)};
    e.out_a     = 14'(clamp_sample(s_a));
    e.out_b     = 14'(clamp_sample(s_b));
    e.dac_a     = 14'(8191 - clamp_sample(s_a));  // Negative slope DAC code
    e.dac_b     = 14'(8191 - clamp_sample(s_b));
    e.issue_cyc = '0;
    return e;
  endfunction

//////////////////////////////////////////////////////////////////////////////
// Checking
//////////////////////////////////////////////////////////////////////////////

  task automatic check_eq(input int got, input int exp, input string what);
    if (got != exp)
    begin
      errors++;
      $display("Mismatch at %0t ns: %s got %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  // Falling edge compare where outputs have settled
  always @(negedge adc_clk)
  begin
    if (rst_n_i && dac_valid_o)
    begin
      if (expected.size() == 0)
      begin
        errors++;
        $display("Error at %0t ns: DAC strobe with no sample pending", $time);
      end
      else
      begin
        exp_s = expected.pop_front();
        check_eq(out_a_o, exp_s.out_a, "signed sum a");
        check_eq(out_b_o, exp_s.out_b, "signed sum b");
        check_eq(dac_dat_a_o, exp_s.dac_a, "DAC code a");
        check_eq(dac_dat_b_o, exp_s.dac_b, "DAC code b");
        check_eq(dac_sat_o, exp_s.sat, "saturation flags");
        check_eq(cycle - int'(exp_s.issue_cyc), 3, "strobe to DAC latency");
      end
    end
  end

  // Cycle count and run limit
  always @(posedge adc_clk)
  begin
    cycle <= cycle + 1;
    if (cycle >= TIMEOUT_CYCLES)
    begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Done: %0d samples issued, %0d errors", issued, errors + 1);
      $display("** FAIL **");
      $finish;
    end
  end

//////////////////////////////////////////////////////////////////////////////
// Stimulus tasks that start and end on a falling edge
//////////////////////////////////////////////////////////////////////////////

  task automatic apply_reset;
    rst_n_i = 1'b0;
    repeat (2) @(negedge adc_clk);
    rst_n_i   = 1'b1;
    prev_a    = 0;   // Mixer pair clears
    prev_b    = 0;
    model_acc = '0;
    check_eq(dac_valid_o, 0, "reset dac_valid_o");
    check_eq(dac_dat_a_o, 8191, "reset DAC code a");
    check_eq(dac_dat_b_o, 8191, "reset DAC code b");
    check_eq(dac_sat_o, 0, "reset saturation flags");
  endtask

  // One idle cycle first so in-flight samples see the old settings
  task automatic set_config(
    input analog_pkg::gen_mode_e mode,
    input int                    level,
    input logic [ACC_W-1:0]      step,
    input int                    sp,
    input int                    kp,
    input bit                    loop_en
  );
    @(negedge adc_clk);
    gen_mode_i  = mode;
    gen_level_i = 14'(level);
    gen_step_i  = step;
    setpoint_i  = 14'(sp);
    kp_i        = 8'(kp);
    loop_en_i   = loop_en;
    if (mode != analog_pkg::GEN_RAMP)
      model_acc = '0;   // Phase held at zero outside ramp mode
  endtask

  task automatic issue_sample(input logic [15:0] raw_a, input logic [15:0] raw_b);
    expect_t e;
    e = model_sample(raw_a, raw_b, gen_mode_i, gen_level_i, model_acc, gen_step_i,
                     setpoint_i, kp_i, loop_en_i, prev_a, prev_b);
    e.issue_cyc = 32'(cycle);
    expected.push_back(e);
    if (gen_mode_i == analog_pkg::GEN_RAMP)
      model_acc = model_acc + gen_step_i;
    prev_a = e.out_a;   // Next loopback input
    prev_b = e.out_b;
    issued++;
    adc_dat_a_i = raw_a;
    adc_dat_b_i = raw_b;
    adc_valid_i = 1'b1;
    @(negedge adc_clk);
    adc_valid_i = 1'b0;
  endtask

  // Raw ADC word that converts to a given signed sample
  function automatic logic [15:0] raw_from_signed(input int x);
    logic [13:0] top;
    top = 14'(8191 - x);
    return {top, 2'b00};
  endfunction

  task automatic drain_pipeline;
    int waited;
    waited = 0;
    while (expected.size() != 0 && waited < 8)
    begin
      @(negedge adc_clk);
      waited++;
    end
    if (expected.size() != 0)
    begin
      $display("Error at %0t ns: %0d expected samples never reached the DAC",
               $time, expected.size());
      errors += expected.size();
      expected.delete();
    end
  endtask

//////////////////////////////////////////////////////////////////////////////
// Test sequence
//////////////////////////////////////////////////////////////////////////////

  initial
  begin
    int kp_list[6];
    int lvl;
    seed        = 32'h4b4d;
    cycle       = 0;
    errors      = 0;
    issued      = 0;
    rst_n_i     = 1'b0;
    adc_valid_i = 1'b0;
    adc_dat_a_i = '0;
    adc_dat_b_i = '0;
    loop_en_i   = 1'b0;
    gen_mode_i  = analog_pkg::GEN_OFF;
    gen_level_i = '0;
    gen_step_i  = '0;
    setpoint_i  = '0;
    kp_i        = '0;
    kp_list     = '{64, -64, 127, -128, 5, -3};
    @(negedge adc_clk);
    apply_reset();

    // Constant level with zero controller gain and back to back strobes
    for (int g = 0; g < 4; g++)
    begin
      lvl = int'(14'($random(seed)));
      set_config(analog_pkg::GEN_CONST, lvl, '0, 0, 0, 1'b0);
      for (int i = 0; i < 4; i++)
        issue_sample(16'($random(seed)), 16'($random(seed)));
    end
    drain_pipeline();

    // ADC conversion and proportional term with the generator off
    foreach (kp_list[k])
    begin
      set_config(analog_pkg::GEN_OFF, 0, '0, $random(seed) % 8192, kp_list[k], 1'b0);
      for (int i = 0; i < 5; i++)
        issue_sample(16'($random(seed)), 16'($random(seed)));
    end
    drain_pipeline();

    // Ramp with a random step
    set_config(analog_pkg::GEN_RAMP, 0, ACC_W'($random(seed)), 0, 0, 1'b0);
    for (int i = 0; i < N_RAMP; i++)
      issue_sample(16'($random(seed)), 16'($random(seed)));
    drain_pipeline();

    // Saturation cases
    set_config(analog_pkg::GEN_CONST, 8191, '0, 8191, 127, 1'b0);
    issue_sample(raw_from_signed(-8192), raw_from_signed(-8192));  // Both high
    set_config(analog_pkg::GEN_CONST, -8192, '0, -8192, 127, 1'b0);
    issue_sample(raw_from_signed(8191), raw_from_signed(8191));    // Both low
    set_config(analog_pkg::GEN_CONST, 6000, '0, 0, 64, 1'b0);
    issue_sample(raw_from_signed(-4000), raw_from_signed(4000));   // Only a
    set_config(analog_pkg::GEN_CONST, 6000, '0, 0, 64, 1'b0);
    issue_sample(raw_from_signed(4000), raw_from_signed(-4000));   // Only b
    set_config(analog_pkg::GEN_CONST, -8000, '0, 100, -128, 1'b0);
    issue_sample(raw_from_signed(-100), raw_from_signed(100));     // a low
    set_config(analog_pkg::GEN_CONST, 8191, '0, 0, 0, 1'b0);
    issue_sample(16'($random(seed)), 16'($random(seed)));          // At the edge unclamped
    drain_pipeline();

    // Closed loop through the digital loopback from a fresh reset
    apply_reset();
    set_config(analog_pkg::GEN_CONST, 500, '0, 4000, 40, 1'b1);
    for (int i = 0; i < N_LOOP; i++)
    begin
      issue_sample(16'($random(seed)), 16'($random(seed)));  // ADC ignored
      repeat (3) @(negedge adc_clk);
    end
    drain_pipeline();

    repeat (4) @(negedge adc_clk);
    if (expected.size() != 0)
    begin
      errors++;
      $display("Error: %0d expected samples left over at the end", expected.size());
    end
    $display("Done: %0d samples issued, %0d errors", issued, errors);
    if (errors == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

// File: analog_loop.f
design/analog_pkg.sv
design/adc_frontend.sv
design/waveform_generator.sv
design/p_controller.sv
design/dac_mixer.sv
design/analog_loop_top.sv
test/tb_analog_loop.sv

// File: run_sim.sh
#!/bin/sh
# Builds the analog loop testbench with Verilator and runs it.
# Exit status is non-zero on a build error, a crash or a reported failure.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log
TOP=tb_analog_loop

verilator --binary --timing --assert -Wno-fatal \
  -f analog_loop.f \
  --top-module "$TOP" \
  -Mdir "$BUILD_DIR" \
  -o "$TOP"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q -F '** FAIL **' "$LOG"; then
  echo "Simulation reported failure, see $LOG"
  exit 1
fi

echo "Simulation passed"
exit 0
